// ==== src/rx_bist_pkg.sv ====
`default_nettype none

package rx_bist_pkg;

    // datapath sizes
    localparam int N_TI   = 16;
    localparam int N_ADC  = 8;
    localparam int N_PRBS = 32;
    localparam int CNT_W  = 64;

    // width of a per-cycle population count over all channels
    localparam int POP_W  = $clog2(N_TI + 1);

    // register port
    localparam int REG_AW = 4;
    localparam int REG_DW = 32;

    typedef enum logic [REG_AW-1:0] {
        REG_GEN_EQN    = 4'd0,
        REG_GEN_INIT   = 4'd1,
        REG_GEN_CTRL   = 4'd2,
        REG_CHK_EQN    = 4'd3,
        REG_CHK_CTRL   = 4'd4,
        REG_CHAN_SEL   = 4'd5,
        REG_ADC_THRESH = 4'd6,
        REG_ERR_LO     = 4'd7,
        REG_ERR_HI     = 4'd8,
        REG_TOT_LO     = 4'd9,
        REG_TOT_HI     = 4'd10
    } reg_addr_e;

    typedef enum logic [1:0] {
        MODE_RESET  = 2'd0,
        MODE_ALIGN  = 2'd1,
        MODE_TEST   = 2'd2,
        MODE_FREEZE = 2'd3
    } chk_mode_e;

    // sliced adc bits or the bist generator bit
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

endpackage

`default_nettype wire

// ==== src/bist_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module bist_cfg_regs import rx_bist_pkg::*; (
    input  wire logic                     clk_adc,
    input  wire logic                     rst_n_i,
    input  wire logic                     cfg_we_i,
    input  wire reg_addr_e                cfg_addr_i,
    input  wire logic [REG_DW-1:0]        cfg_wdata_i,
    input  wire logic [CNT_W-1:0]         err_cnt_i,
    input  wire logic [CNT_W-1:0]         tot_cnt_i,
    output logic      [REG_DW-1:0]        cfg_rdata_o,
    output logic      [N_PRBS-1:0]        gen_eqn_o,
    output logic      [N_PRBS-1:0]        gen_init_o,
    output logic                          gen_cke_o,
    output logic                          gen_inv_o,
    output logic                          gen_inj_err_o,
    output logic      [N_PRBS-1:0]        chk_eqn_o,
    output chk_mode_e                     chk_mode_o,
    output prbs_src_e                     chk_src_o,
    output logic                          chk_cke_o,
    output logic      [N_TI-1:0]          chan_sel_o,
    output logic signed [N_ADC-1:0]       adc_thresh_o
);

    logic inj_req;

    // bit 2 of the generator control word is a request, never stored
    assign inj_req = cfg_we_i && (cfg_addr_i == REG_GEN_CTRL) && cfg_wdata_i[2];

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gen_eqn_o     <= '0;
            gen_init_o    <= '0;
            gen_cke_o     <= 1'b0;
            gen_inv_o     <= 1'b0;
            gen_inj_err_o <= 1'b0;
            chk_eqn_o     <= '0;
            chk_mode_o    <= MODE_RESET;
            chk_src_o     <= SRC_ADC;
            chk_cke_o     <= 1'b0;
            chan_sel_o    <= '1;
            adc_thresh_o  <= '0;
        end else begin
            gen_inj_err_o <= inj_req;
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    REG_GEN_EQN:    gen_eqn_o  <= cfg_wdata_i[N_PRBS-1:0];
                    REG_GEN_INIT:   gen_init_o <= cfg_wdata_i[N_PRBS-1:0];
                    REG_GEN_CTRL: begin
                        gen_cke_o <= cfg_wdata_i[0];
                        gen_inv_o <= cfg_wdata_i[1];
                    end
                    REG_CHK_EQN:    chk_eqn_o  <= cfg_wdata_i[N_PRBS-1:0];
                    REG_CHK_CTRL: begin
                        chk_mode_o <= chk_mode_e'(cfg_wdata_i[1:0]);
                        chk_src_o  <= prbs_src_e'(cfg_wdata_i[2]);
                        chk_cke_o  <= cfg_wdata_i[3];
                    end
                    REG_CHAN_SEL:   chan_sel_o   <= cfg_wdata_i[N_TI-1:0];
                    REG_ADC_THRESH: adc_thresh_o <= cfg_wdata_i[N_ADC-1:0];
                    // counter words are read only
                    default: ;
                endcase
            end
        end
    end

    // readback, combinational from the address
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            REG_GEN_EQN:    cfg_rdata_o = gen_eqn_o;
            REG_GEN_INIT:   cfg_rdata_o = gen_init_o;
            REG_GEN_CTRL:   cfg_rdata_o = {{(REG_DW-2){1'b0}}, gen_inv_o, gen_cke_o};
            REG_CHK_EQN:    cfg_rdata_o = chk_eqn_o;
            REG_CHK_CTRL: begin
                cfg_rdata_o = {{(REG_DW-4){1'b0}}, chk_cke_o, chk_src_o, chk_mode_o};
            end
            REG_CHAN_SEL:   cfg_rdata_o = {{(REG_DW-N_TI){1'b0}}, chan_sel_o};
            REG_ADC_THRESH: cfg_rdata_o = {{(REG_DW-N_ADC){1'b0}}, adc_thresh_o};
            // 64-bit counters split into two words
            REG_ERR_LO:     cfg_rdata_o = err_cnt_i[REG_DW-1:0];
            REG_ERR_HI:     cfg_rdata_o = err_cnt_i[CNT_W-1:REG_DW];
            REG_TOT_LO:     cfg_rdata_o = tot_cnt_i[REG_DW-1:0];
            REG_TOT_HI:     cfg_rdata_o = tot_cnt_i[CNT_W-1:REG_DW];
            default:        cfg_rdata_o = '0;
        endcase
    end

    // an injection request must flip a single generator bit
    a_inj_single_cycle: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        gen_inj_err_o |=> !gen_inj_err_o
    ) else $error("gen_inj_err_o high for two cycles in a row");

endmodule

`default_nettype wire

// ==== src/adc_slicer.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_slicer import rx_bist_pkg::*; (
    input  wire logic                  clk_adc,
    input  wire logic                  rst_n_i,
    input  wire logic signed [N_ADC-1:0] adc_code_i [N_TI-1:0],
    input  wire logic signed [N_ADC-1:0] adc_thresh_i,
    output logic [N_TI-1:0]            adc_bits_o
);

    logic [N_TI-1:0] above;

    // signed compare per interleaved channel, shared threshold
    always_comb begin
        for (int i = 0; i < N_TI; i++) begin
            above[i] = (adc_code_i[i] > adc_thresh_i);
        end
    end

    // one register stage, bit lands one edge after its code
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            adc_bits_o <= '0;
        end else begin
            adc_bits_o <= above;
        end
    end

endmodule

`default_nettype wire

// ==== src/prbs_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_generator import rx_bist_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic              cke_i,
    input  wire logic [N_PRBS-1:0] eqn_i,
    input  wire logic [N_PRBS-1:0] init_i,
    input  wire logic              inv_i,
    input  wire logic              inj_err_i,
    output logic                   prbs_bit_o
);

    logic [N_PRBS-1:0] state_q;
    logic              fb_bit;

    // fibonacci feedback, parity of the tapped state bits
    assign fb_bit = ^(state_q & eqn_i);

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= '0;
            prbs_bit_o <= 1'b0;
        end else if (cke_i) begin
            state_q    <= {state_q[N_PRBS-2:0], fb_bit};
            // injection flips only this one output bit, state stays clean
            prbs_bit_o <= fb_bit ^ inv_i ^ inj_err_i;
        end else begin
            // seed reload while stopped, output holds
            state_q    <= init_i;
        end
    end

    // a nonzero seed must never lock the lfsr at zero
    a_state_nonzero: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        cke_i |-> (state_q != '0) || (init_i == '0)
    ) else $error("prbs generator state is all zeros with a nonzero seed");

endmodule

`default_nettype wire

// ==== src/prbs_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_checker import rx_bist_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic              cke_i,
    input  wire chk_mode_e         mode_i,
    input  wire prbs_src_e         src_i,
    input  wire logic [N_PRBS-1:0] eqn_i,
    input  wire logic [N_TI-1:0]   chan_sel_i,
    input  wire logic [N_TI-1:0]   adc_bits_i,
    input  wire logic              bist_bit_i,
    output logic [CNT_W-1:0]       err_cnt_o,
    output logic [CNT_W-1:0]       tot_cnt_o
);

    logic [N_TI-1:0]   rx_bits;
    logic [N_PRBS-1:0] chan_state_q [N_TI-1:0];
    logic [N_TI-1:0]   predicted;
    logic [N_TI-1:0]   err_sel;
    logic [POP_W-1:0]  err_pop;
    logic [POP_W-1:0]  tot_pop;

    // bist bit goes to every channel
    assign rx_bits = (src_i == SRC_BIST) ? {N_TI{bist_bit_i}} : adc_bits_i;

    // self-synchronizing predictor per channel
    always_comb begin
        for (int i = 0; i < N_TI; i++) begin
            predicted[i] = ^(chan_state_q[i] & eqn_i);
        end
    end

    assign err_sel = (predicted ^ rx_bits) & chan_sel_i;

    // population counts of selected mismatches and selected channels
    always_comb begin
        err_pop = '0;
        tot_pop = '0;
        for (int i = 0; i < N_TI; i++) begin
            err_pop = err_pop + POP_W'(err_sel[i]);
            tot_pop = tot_pop + POP_W'(chan_sel_i[i]);
        end
    end

    // channel states
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < N_TI; i++) begin
                chan_state_q[i] <= '0;
            end
        end else if (cke_i) begin
            case (mode_i)
                MODE_RESET: begin
                    for (int i = 0; i < N_TI; i++) begin
                        chan_state_q[i] <= '0;
                    end
                end
                MODE_ALIGN, MODE_TEST: begin
                    // received bit shifts in, whether or not it matched
                    for (int i = 0; i < N_TI; i++) begin
                        chan_state_q[i] <= {chan_state_q[i][N_PRBS-2:0], rx_bits[i]};
                    end
                end
                default: ;
            endcase
        end
    end

    // counters, a cycle's bits show up one edge later
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_cnt_o <= '0;
            tot_cnt_o <= '0;
        end else if (cke_i) begin
            case (mode_i)
                MODE_RESET: begin
                    err_cnt_o <= '0;
                    tot_cnt_o <= '0;
                end
                MODE_TEST: begin
                    err_cnt_o <= err_cnt_o + CNT_W'(err_pop);
                    tot_cnt_o <= tot_cnt_o + CNT_W'(tot_pop);
                end
                // align and freeze leave the counts alone
                default: ;
            endcase
        end
    end

    a_tot_monotonic: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        (tot_cnt_o < $past(tot_cnt_o)) |-> $past(cke_i && mode_i == MODE_RESET)
    ) else $error("tot_cnt_o decreased outside of reset mode");

    a_err_le_tot: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        err_cnt_o <= tot_cnt_o
    ) else $error("err_cnt_o exceeds tot_cnt_o");

endmodule

`default_nettype wire

// ==== src/rx_bist_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_bist_core import rx_bist_pkg::*; (
    input  wire logic                    clk_adc,
    input  wire logic                    rst_n_i,
    input  wire logic signed [N_ADC-1:0] adc_code_i [N_TI-1:0],
    input  wire logic                    cfg_we_i,
    input  wire reg_addr_e               cfg_addr_i,
    input  wire logic [REG_DW-1:0]       cfg_wdata_i,
    output logic [REG_DW-1:0]            cfg_rdata_o
);

    // generator control
    logic [N_PRBS-1:0]        gen_eqn;
    logic [N_PRBS-1:0]        gen_init;
    logic                     gen_cke;
    logic                     gen_inv;
    logic                     gen_inj_err;
    logic                     bist_bit;

    // checker control and results
    logic [N_PRBS-1:0]        chk_eqn;
    chk_mode_e                chk_mode;
    prbs_src_e                chk_src;
    logic                     chk_cke;
    logic [N_TI-1:0]          chan_sel;
    logic [CNT_W-1:0]         err_cnt;
    logic [CNT_W-1:0]         tot_cnt;

    // slicer
    logic signed [N_ADC-1:0]  adc_thresh;
    logic [N_TI-1:0]          adc_bits;

    bist_cfg_regs bist_cfg_regs_i (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .err_cnt_i     (err_cnt),
        .tot_cnt_i     (tot_cnt),
        .cfg_rdata_o   (cfg_rdata_o),
        .gen_eqn_o     (gen_eqn),
        .gen_init_o    (gen_init),
        .gen_cke_o     (gen_cke),
        .gen_inv_o     (gen_inv),
        .gen_inj_err_o (gen_inj_err),
        .chk_eqn_o     (chk_eqn),
        .chk_mode_o    (chk_mode),
        .chk_src_o     (chk_src),
        .chk_cke_o     (chk_cke),
        .chan_sel_o    (chan_sel),
        .adc_thresh_o  (adc_thresh)
    );

    adc_slicer adc_slicer_i (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .adc_code_i   (adc_code_i),
        .adc_thresh_i (adc_thresh),
        .adc_bits_o   (adc_bits)
    );

    prbs_generator prbs_generator_i (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .cke_i      (gen_cke),
        .eqn_i      (gen_eqn),
        .init_i     (gen_init),
        .inv_i      (gen_inv),
        .inj_err_i  (gen_inj_err),
        .prbs_bit_o (bist_bit)
    );

    prbs_checker prbs_checker_i (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .cke_i      (chk_cke),
        .mode_i     (chk_mode),
        .src_i      (chk_src),
        .eqn_i      (chk_eqn),
        .chan_sel_i (chan_sel),
        .adc_bits_i (adc_bits),
        .bist_bit_i (bist_bit),
        .err_cnt_o  (err_cnt),
        .tot_cnt_o  (tot_cnt)
    );

endmodule

`default_nettype wire

// ==== test/tb_rx_bist_tasks.svh ====
`ifndef TB_RX_BIST_TASKS_SVH
`define TB_RX_BIST_TASKS_SVH

// advance one clock and settle 1 ns past the edge
task automatic step();
    @(posedge clk_adc);
    #1;
endtask

task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        step();
    end
endtask

task automatic reg_write(input reg_addr_e addr, input logic [REG_DW-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    step();
    cfg_we    = 1'b0;
endtask

// readback is combinational and sampled once it settles
task automatic reg_read(input reg_addr_e addr, output logic [REG_DW-1:0] data);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
endtask

task automatic check_value(input string name, input logic [CNT_W-1:0] got,
                           input logic [CNT_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error: %s", what);
    end
endtask

task automatic check_reg(input reg_addr_e addr, input logic [REG_DW-1:0] exp,
                         input string name);
    logic [REG_DW-1:0] rd;
    reg_read(addr, rd);
    check_value(name, CNT_W'(rd), CNT_W'(exp));
endtask

// HI word sits at the address after LO
task automatic read_count(input reg_addr_e lo_addr, output logic [CNT_W-1:0] cnt);
    logic [REG_DW-1:0] lo;
    logic [REG_DW-1:0] hi;
    reg_read(lo_addr, lo);
    reg_read(reg_addr_e'(lo_addr + 4'd1), hi);
    cnt = {hi, lo};
endtask

// checker clock enable always on here
task automatic set_mode(input chk_mode_e mode, input prbs_src_e src);
    reg_write(REG_CHK_CTRL, {{(REG_DW-4){1'b0}}, 1'b1, src, mode});
endtask

task automatic timeout_hit(input string what);
    $display("timeout: %s did not happen in time", what);
    // the closing block ends the run
    timed_out = 1'b1;
endtask

task automatic wait_count_reach(input reg_addr_e addr, input logic [REG_DW-1:0] target,
                                input int max_cycles, input string what);
    logic [REG_DW-1:0] rd;
    int                n;
    n = 0;
    reg_read(addr, rd);
    while (rd < target && n < max_cycles) begin
        step();
        n++;
        reg_read(addr, rd);
    end
    if (rd < target) begin
        timeout_hit(what);
    end
endtask

// random code on the correct side of the threshold
function automatic logic signed [N_ADC-1:0] code_for_bit(input logic b);
    int c;
    if (b) begin
        c = thresh_val + 1 + int'($urandom_range(126 - thresh_val, 0));
    end else begin
        c = -128 + int'($urandom_range(thresh_val + 128, 0));
    end
    return N_ADC'(c);
endfunction

// PRBS7 reference with the same bit on every channel
task automatic drive_adc_cycle();
    logic bit_now;
    bit_now  = ref_lfsr[6] ^ ref_lfsr[5];
    ref_lfsr = {ref_lfsr[5:0], bit_now};
    for (int ch = 0; ch < N_TI; ch++) begin
        if (scramble) begin
            adc_code[ch] = N_ADC'($urandom);
        end else begin
            adc_code[ch] = code_for_bit(bit_now ^ (ch == flip_chan));
        end
    end
    if (flip_chan >= 0) begin
        flip_chan <= -1;
    end
endtask

`endif

// ==== test/tb_rx_bist.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rx_bist import rx_bist_pkg::*; ();

    logic                    clk_adc;
    logic                    rst_n_i;
    logic signed [N_ADC-1:0] adc_code [N_TI-1:0];
    logic                    cfg_we;
    reg_addr_e               cfg_addr;
    logic [REG_DW-1:0]       cfg_wdata;
    logic [REG_DW-1:0]       cfg_rdata;

    int   checks;
    int   errors;
    bit   timed_out;
    bit   run_done;
    bit   freeze_watch;

    // adc stimulus state
    logic [6:0] ref_lfsr;
    int         thresh_val;
    int         flip_chan;
    bit         scramble;

    `include "tb_rx_bist_tasks.svh"

    rx_bist_core rx_bist_core_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .adc_code_i  (adc_code),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata)
    );

    initial begin
        clk_adc = 1'b0;
        forever #4 clk_adc = ~clk_adc;
    end

    // counter words must not move while frozen
    a_freeze_stable: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        (freeze_watch && $past(freeze_watch)) |-> $stable(cfg_rdata)
    ) else begin
        errors++;
        $display("CHECK FAILED cfg_rdata_o changed during freeze, now 0x%0h", cfg_rdata);
    end

    initial begin
        forever begin
            @(posedge clk_adc);
            #1;
            drive_adc_cycle();
        end
    end

    initial begin
        logic [REG_DW-1:0] rnd;
        logic [REG_DW-1:0] prbs7_eqn;
        logic [N_TI-1:0]   mask;
        logic [CNT_W-1:0]  err_cnt;
        logic [CNT_W-1:0]  tot_cnt;
        logic [CNT_W-1:0]  err_hold;
        logic [CNT_W-1:0]  tot_hold;
        int                thr;
        int                pop;
        int                n_inj;

        rnd = $urandom(32'h7585);
        rst_n_i   = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = REG_GEN_EQN;
        cfg_wdata = '0;
        for (int ch = 0; ch < N_TI; ch++) begin
            adc_code[ch] = '0;
        end
        ref_lfsr   = 7'($urandom_range(127, 1));
        thresh_val = 0;
        flip_chan  = -1;
        scramble   = 1'b0;
        // taps at bits 6 and 5
        prbs7_eqn  = 32'h0000_0060;
        repeat (10) @(posedge clk_adc);
        #1;
        rst_n_i = 1'b1;

        // reset values and zero reads from unused addresses
        check_reg(REG_GEN_EQN, '0, "gen_eqn");
        check_reg(REG_GEN_INIT, '0, "gen_init");
        check_reg(REG_GEN_CTRL, '0, "gen_ctrl");
        check_reg(REG_CHK_EQN, '0, "chk_eqn");
        check_reg(REG_CHK_CTRL, '0, "chk_ctrl");
        check_reg(REG_CHAN_SEL, 32'h0000_ffff, "chan_sel");
        check_reg(REG_ADC_THRESH, '0, "adc_thresh");
        for (int a = 7; a < 16; a++) begin
            check_reg(reg_addr_e'(a[3:0]), '0, "counter or unused word");
        end

        // readback
        rnd = $urandom;
        reg_write(REG_GEN_EQN, rnd);
        check_reg(REG_GEN_EQN, rnd, "gen_eqn");
        rnd = $urandom;
        reg_write(REG_GEN_INIT, rnd);
        check_reg(REG_GEN_INIT, rnd, "gen_init");
        rnd = $urandom;
        reg_write(REG_CHK_EQN, rnd);
        check_reg(REG_CHK_EQN, rnd, "chk_eqn");
        rnd = $urandom & 32'hf;
        reg_write(REG_CHK_CTRL, rnd);
        check_reg(REG_CHK_CTRL, rnd, "chk_ctrl");
        // injection request bit is not stored
        reg_write(REG_GEN_CTRL, 32'h6);
        check_reg(REG_GEN_CTRL, 32'h2, "gen_ctrl");
        mask = N_TI'($urandom);
        mask[0] = 1'b1;
        mask[N_TI-1] = 1'b0;
        pop = $countones(mask);
        reg_write(REG_CHAN_SEL, {{(REG_DW-N_TI){1'b0}}, mask});
        check_reg(REG_CHAN_SEL, {{(REG_DW-N_TI){1'b0}}, mask}, "chan_sel");
        thr = int'($urandom_range(120, 0)) - 60;
        thresh_val <= thr;
        reg_write(REG_ADC_THRESH, {{(REG_DW-N_ADC){1'b0}}, N_ADC'(thr)});
        check_reg(REG_ADC_THRESH, {{(REG_DW-N_ADC){1'b0}}, N_ADC'(thr)}, "adc_thresh");

        // bist loopback with a seed that is nonzero in the PRBS7 bits
        rnd = $urandom;
        if (rnd[6:0] == 7'd0) begin
            rnd[0] = 1'b1;
        end
        reg_write(REG_GEN_EQN, prbs7_eqn);
        reg_write(REG_GEN_INIT, rnd);
        reg_write(REG_CHK_EQN, prbs7_eqn);
        reg_write(REG_GEN_CTRL, 32'h1);
        check_reg(REG_GEN_CTRL, 32'h1, "gen_ctrl");
        set_mode(MODE_RESET, SRC_BIST);
        set_mode(MODE_ALIGN, SRC_BIST);
        wait_cycles(40);
        set_mode(MODE_TEST, SRC_BIST);
        wait_count_reach(REG_TOT_LO, 32'd1, 20, "loopback total count");
        wait_cycles($urandom_range(200, 50));
        set_mode(MODE_FREEZE, SRC_BIST);
        read_count(REG_ERR_LO, err_cnt);
        read_count(REG_TOT_LO, tot_cnt);
        check_value("err_cnt", err_cnt, '0);
        check_true(tot_cnt != '0 && (tot_cnt % CNT_W'(pop)) == '0,
                   "loopback total is not a nonzero multiple of the selected channels");

        // each injected flip gives three errors per selected channel
        set_mode(MODE_RESET, SRC_BIST);
        set_mode(MODE_ALIGN, SRC_BIST);
        wait_cycles(40);
        set_mode(MODE_TEST, SRC_BIST);
        n_inj = int'($urandom_range(5, 2));
        for (int i = 0; i < n_inj; i++) begin
            reg_write(REG_GEN_CTRL, 32'h5);
            wait_cycles(12);
        end
        set_mode(MODE_FREEZE, SRC_BIST);
        read_count(REG_ERR_LO, err_cnt);
        check_value("err_cnt", err_cnt, CNT_W'(n_inj * 3 * pop));

        // with two taps the inverted stream misses every prediction
        reg_write(REG_GEN_CTRL, 32'h3);
        set_mode(MODE_RESET, SRC_BIST);
        set_mode(MODE_ALIGN, SRC_BIST);
        wait_cycles(40);
        set_mode(MODE_TEST, SRC_BIST);
        wait_count_reach(REG_TOT_LO, 32'd1, 20, "inverted loopback total count");
        wait_cycles(60);
        set_mode(MODE_FREEZE, SRC_BIST);
        read_count(REG_ERR_LO, err_cnt);
        read_count(REG_TOT_LO, tot_cnt);
        check_value("err_cnt", err_cnt, tot_cnt);

        // adc path with channel 0 selected and channel 15 masked
        set_mode(MODE_RESET, SRC_ADC);
        set_mode(MODE_ALIGN, SRC_ADC);
        wait_cycles(40);
        set_mode(MODE_TEST, SRC_ADC);
        wait_count_reach(REG_TOT_LO, 32'd1, 20, "adc path total count");
        wait_cycles(30);
        read_count(REG_ERR_LO, err_cnt);
        check_value("err_cnt", err_cnt, '0);
        flip_chan <= 0;
        wait_count_reach(REG_ERR_LO, 32'd3, 20, "errors from a flipped code");
        wait_cycles(12);
        read_count(REG_ERR_LO, err_cnt);
        check_value("err_cnt", err_cnt, CNT_W'(3));
        flip_chan <= N_TI - 1;
        wait_cycles(15);
        read_count(REG_ERR_LO, err_cnt);
        check_value("err_cnt", err_cnt, CNT_W'(3));

        // freeze holds under garbage codes
        set_mode(MODE_FREEZE, SRC_ADC);
        read_count(REG_ERR_LO, err_hold);
        read_count(REG_TOT_LO, tot_hold);
        scramble <= 1'b1;
        cfg_addr = REG_ERR_LO;
        freeze_watch = 1'b1;
        wait_cycles(50);
        freeze_watch = 1'b0;
        read_count(REG_ERR_LO, err_cnt);
        read_count(REG_TOT_LO, tot_cnt);
        check_value("err_cnt", err_cnt, err_hold);
        check_value("tot_cnt", tot_cnt, tot_hold);
        run_done = 1'b1;
    end

    initial begin
        int cyc;
        cyc = 0;
        while (!run_done && !timed_out && cyc < 20000) begin
            @(posedge clk_adc);
            cyc++;
        end
        if (!run_done && !timed_out) begin
            $display("timeout: the test sequence did not finish in time");
            timed_out = 1'b1;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
src/rx_bist_pkg.sv
src/bist_cfg_regs.sv
src/adc_slicer.sv
src/prbs_generator.sv
src/prbs_checker.sv
src/rx_bist_core.sv
test/tb_rx_bist.sv

// ==== Makefile ====
.PHONY: sim clean

# the verdict is the exit status of the final grep
sim:
	verilator --binary --timing --assert --top-module tb_rx_bist -f project.f
	./obj_dir/Vtb_rx_bist | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
